// File: hw/sdram_port_pkg.sv
// SDRAM side request port: address, data and strobe widths
// port select codes and the WRAM placement in the SDRAM map

package sdram_port_pkg;

    // cpu port byte address, bit 0 picks the lane
    localparam int cpu_addr_w = 24;

    // one sdram word, two byte lanes
    localparam int data_w = 16;
    localparam int ds_w   = 2;

    // upper address bits for WRAM, banks EE and EF
    // 128KB sits at 0xEE0000 to 0xEFFFFF
    localparam logic [6:0] wram_prefix = 7'b1110_111;

    // cpu port select
    localparam logic port_rom  = 1'b0; // read data returns on cpu_port0
    localparam logic port_wram = 1'b1; // read data returns on cpu_port1

endpackage

// File: hw/snes_bus_pkg.sv
// SNES core memory buses: ROM, WRAM, BSRAM and ARAM widths
// core reset hold length and map type codes

package snes_bus_pkg;

    // core side address widths
    localparam int rom_addr_w   = 24;
    localparam int wram_addr_w  = 17; // 128KB
    localparam int bsram_addr_w = 20;
    localparam int aram_addr_w  = 16; // 64KB audio ram

    // core data buses are byte wide
    localparam int byte_w = 8;

    // cartridge map type from the rom header
    localparam int map_type_w = 8;

    // SA-1 style maps read BSRAM without rd_n
    localparam logic [3:0] map_sa_nibble = 4'hC;

    // core reset hold after resetn, in wclk cycles
    localparam int reset_hold  = 16;
    localparam int reset_cnt_w = 5;  // must hold reset_hold

endpackage

// File: hw/reset_enable.sv
// core reset sequencer with start switch and loader hold
// registered run enable and enable-qualified clock-enable phases

`timescale 1ns/100ps

module reset_enable (
    input  logic wclk,
    input  logic resetn,
    input  logic start,        // start switch
    input  logic loading,      // rom load in progress
    input  logic sdram_busy,
    input  logic loader_fail,
    input  logic frame_pause,  // video frame sync hold
    input  logic sysclkf_ce,
    input  logic sysclkr_ce,
    output logic core_resetn,
    output logic enable,
    output logic f_ce,
    output logic r_ce
);
    import snes_bus_pkg::*;

    logic [reset_cnt_w-1:0] hold_cnt;
    logic                   released; // hold done and start seen

    // hold counter, reloads under reset
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            hold_cnt <= reset_cnt_w'(reset_hold);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // sticky once released
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            released <= 1'b0;
        end else if (hold_cnt == '0 && start) begin
            released <= 1'b1;
        end
    end

    assign core_resetn = released & ~loading; // core held while loader runs

    // run enable and phase strobes, one cycle behind their inputs
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
            f_ce   <= 1'b0;
            r_ce   <= 1'b0;
        end else begin
            enable <= ~sdram_busy & ~loader_fail & ~frame_pause;
            f_ce   <= sysclkf_ce & enable; // fall phase, reads
            r_ce   <= sysclkr_ce & enable; // rise phase, writes
        end
    end

endmodule

// File: hw/cpu_port_router.sv
// loader write address counter
// fixed priority request mux onto the SDRAM cpu port: loader, ROM, WRAM
// ROM byte swap and WRAM byte select on returned read data

`timescale 1ns/100ps

module cpu_port_router (
    input  logic                                 wclk,
    input  logic                                 resetn,
    // loader
    input  logic                                 loading,
    input  logic [snes_bus_pkg::byte_w-1:0]      loader_do,
    input  logic                                 loader_do_valid,
    // qualified phases
    input  logic                                 f_ce,
    input  logic                                 r_ce,
    // ROM bus
    input  logic [snes_bus_pkg::rom_addr_w-1:0]  rom_addr,
    input  logic                                 rom_ce_n,
    input  logic                                 rom_word,   // 16-bit access
    output logic [sdram_port_pkg::data_w-1:0]    rom_q,
    // WRAM bus
    input  logic [snes_bus_pkg::wram_addr_w-1:0] wram_addr,
    input  logic                                 wram_ce_n,
    input  logic                                 wram_rd_n,
    input  logic                                 wram_we_n,
    input  logic [snes_bus_pkg::byte_w-1:0]      wram_d,
    output logic [snes_bus_pkg::byte_w-1:0]      wram_q,
    // sdram cpu port
    output logic [sdram_port_pkg::cpu_addr_w-1:0] cpu_addr,
    output logic [sdram_port_pkg::data_w-1:0]     cpu_din,
    output logic [sdram_port_pkg::ds_w-1:0]       cpu_ds,
    output logic                                  cpu_port,
    output logic                                  cpu_rd,
    output logic                                  cpu_wr,
    input  logic [sdram_port_pkg::data_w-1:0]     cpu_port0,  // rom read data
    input  logic [sdram_port_pkg::data_w-1:0]     cpu_port1   // wram read data
);
    import sdram_port_pkg::*;
    import snes_bus_pkg::*;

    logic [cpu_addr_w-1:0] loader_addr;
    logic                  loading_r;   // for rising edge of loading
    logic                  wram_rd;
    logic                  wram_wr;

    // next request, registered below
    logic [cpu_addr_w-1:0] req_addr;
    logic [data_w-1:0]     req_din;
    logic [ds_w-1:0]       req_ds;
    logic                  req_port;
    logic                  req_rd;
    logic                  req_wr;

    // loader address counter
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            if (loading && !loading_r) begin
                loader_addr <= '0;                          // new image starts at 0
            end else if (loading && loader_do_valid) begin
                loader_addr <= loader_addr + cpu_addr_w'(1);
            end
        end
    end

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // priority: loader, then rom, then wram
    always_comb begin
        req_addr = '0;
        req_din  = '0;
        req_ds   = '0;
        req_port = port_rom;
        req_rd   = 1'b0;
        req_wr   = 1'b0;
        if (loading && loader_do_valid) begin
            // byte on both lanes, lsb picks the strobe
            req_addr = loader_addr;
            req_din  = {loader_do, loader_do};
            req_ds   = {loader_addr[0], ~loader_addr[0]};
            req_wr   = 1'b1;
        end else if (!rom_ce_n && f_ce) begin
            req_addr = rom_addr;
            req_ds   = '1;           // always a full word
            req_rd   = 1'b1;
        end else if (wram_rd || wram_wr) begin
            req_addr = {wram_prefix, wram_addr};
            req_din  = {wram_d, wram_d};
            req_ds   = {wram_addr[0], ~wram_addr[0]};
            req_port = port_wram;
            req_rd   = wram_rd & f_ce;  // reads on fall phase
            req_wr   = wram_wr & r_ce;  // writes on rise phase
        end
    end

    // strobes
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_rd <= 1'b0;
            cpu_wr <= 1'b0;
        end else begin
            cpu_rd <= req_rd;
            cpu_wr <= req_wr;
        end
    end

    // request payload
    always_ff @(posedge wclk) begin
        cpu_addr <= req_addr;
        cpu_din  <= req_din;
        cpu_ds   <= req_ds;
        cpu_port <= req_port;
    end

    // odd byte reads get the high byte moved down
    assign rom_q = (rom_word || !rom_addr[0]) ? cpu_port0
                 : {cpu_port0[byte_w-1:0], cpu_port0[data_w-1:byte_w]};

    assign wram_q = wram_addr[0] ? cpu_port1[data_w-1:byte_w] : cpu_port1[byte_w-1:0];

endmodule

// File: hw/aux_port_stage.sv
// BSRAM request register with the SA map read exception
// ARAM strobe decode, write lane fan-out and read byte latch

`timescale 1ns/100ps

module aux_port_stage (
    input  logic                                  wclk,
    input  logic                                  resetn,
    input  logic                                  f_ce,
    input  logic                                  r_ce,
    input  logic [snes_bus_pkg::map_type_w-1:0]   map_type,
    // BSRAM bus
    input  logic [snes_bus_pkg::bsram_addr_w-1:0] bsram_addr,
    input  logic                                  bsram_ce_n,
    input  logic                                  bsram_rd_n,
    input  logic                                  bsram_we_n,
    input  logic [snes_bus_pkg::byte_w-1:0]       bsram_d,
    // ARAM bus
    input  logic [snes_bus_pkg::aram_addr_w-1:0]  aram_addr,
    input  logic                                  aram_ce_n,
    input  logic                                  aram_oe_n,
    input  logic                                  aram_we_n,
    input  logic [snes_bus_pkg::byte_w-1:0]       aram_d,
    output logic [snes_bus_pkg::byte_w-1:0]       aram_q,
    // sdram side
    output logic [snes_bus_pkg::bsram_addr_w-1:0] bsram_req_addr,
    output logic [snes_bus_pkg::byte_w-1:0]       bsram_req_din,
    output logic                                  bsram_req_rd,
    output logic                                  bsram_req_wr,
    output logic                                  aram_rd,
    output logic                                  aram_wr,
    output logic [sdram_port_pkg::data_w-1:0]     aram_din,
    input  logic [sdram_port_pkg::data_w-1:0]     aram_dout
);
    import sdram_port_pkg::*;
    import snes_bus_pkg::*;

    logic map_is_sa; // map reads bsram without rd_n
    logic aram_lsb;  // byte lane of the last aram read

    assign map_is_sa = (map_type[map_type_w-1 -: 4] == map_sa_nibble);

    // bsram strobes
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bsram_req_rd <= 1'b0;
            bsram_req_wr <= 1'b0;
        end else begin
            bsram_req_rd <= ~bsram_ce_n & f_ce & (~bsram_rd_n | map_is_sa);
            bsram_req_wr <= ~bsram_ce_n & ~bsram_we_n & r_ce;
        end
    end

    // bsram payload, follows the bus every cycle
    always_ff @(posedge wclk) begin
        bsram_req_addr <= bsram_addr;
        bsram_req_din  <= bsram_d;
    end

    assign aram_rd  = ~aram_ce_n & ~aram_oe_n;
    assign aram_wr  = ~aram_ce_n & ~aram_we_n;
    assign aram_din = {aram_d, aram_d}; // controller strobes the lane

    always_ff @(posedge wclk) begin
        if (aram_rd) aram_lsb <= aram_addr[0];
    end

    assign aram_q = aram_lsb ? aram_dout[data_w-1:byte_w] : aram_dout[byte_w-1:0];

endmodule

// File: hw/snes_mem_top.sv
// SNES memory glue top level
// reset and enable, cpu port router, BSRAM and ARAM stage

`timescale 1ns/100ps

module snes_mem_top (
    input  logic                                   wclk,
    input  logic                                   resetn,
    // control
    input  logic                                   start,
    input  logic                                   sdram_busy,
    input  logic                                   frame_pause,
    output logic                                   core_resetn,
    output logic                                   enable,
    // core phases and cartridge type
    input  logic                                   sysclkf_ce,
    input  logic                                   sysclkr_ce,
    input  logic [snes_bus_pkg::map_type_w-1:0]    map_type,
    // loader
    input  logic                                   loading,
    input  logic [snes_bus_pkg::byte_w-1:0]        loader_do,
    input  logic                                   loader_do_valid,
    input  logic                                   loader_fail,
    // ROM bus
    input  logic [snes_bus_pkg::rom_addr_w-1:0]    rom_addr,
    input  logic                                   rom_ce_n,
    input  logic                                   rom_word,
    output logic [sdram_port_pkg::data_w-1:0]      rom_q,
    // WRAM bus
    input  logic [snes_bus_pkg::wram_addr_w-1:0]   wram_addr,
    input  logic                                   wram_ce_n,
    input  logic                                   wram_rd_n,
    input  logic                                   wram_we_n,
    input  logic [snes_bus_pkg::byte_w-1:0]        wram_d,
    output logic [snes_bus_pkg::byte_w-1:0]        wram_q,
    // BSRAM bus
    input  logic [snes_bus_pkg::bsram_addr_w-1:0]  bsram_addr,
    input  logic                                   bsram_ce_n,
    input  logic                                   bsram_rd_n,
    input  logic                                   bsram_we_n,
    input  logic [snes_bus_pkg::byte_w-1:0]        bsram_d,
    // ARAM bus
    input  logic [snes_bus_pkg::aram_addr_w-1:0]   aram_addr,
    input  logic                                   aram_ce_n,
    input  logic                                   aram_oe_n,
    input  logic                                   aram_we_n,
    input  logic [snes_bus_pkg::byte_w-1:0]        aram_d,
    output logic [snes_bus_pkg::byte_w-1:0]        aram_q,
    // sdram cpu port
    output logic [sdram_port_pkg::cpu_addr_w-1:0]  cpu_addr,
    output logic [sdram_port_pkg::data_w-1:0]      cpu_din,
    output logic [sdram_port_pkg::ds_w-1:0]        cpu_ds,
    output logic                                   cpu_port,
    output logic                                   cpu_rd,
    output logic                                   cpu_wr,
    input  logic [sdram_port_pkg::data_w-1:0]      cpu_port0,
    input  logic [sdram_port_pkg::data_w-1:0]      cpu_port1,
    // sdram bsram port
    output logic [snes_bus_pkg::bsram_addr_w-1:0]  bsram_req_addr,
    output logic [snes_bus_pkg::byte_w-1:0]        bsram_req_din,
    output logic                                   bsram_req_rd,
    output logic                                   bsram_req_wr,
    // sdram aram port
    output logic                                   aram_rd,
    output logic                                   aram_wr,
    output logic [sdram_port_pkg::data_w-1:0]      aram_din,
    input  logic [sdram_port_pkg::data_w-1:0]      aram_dout
);

    logic f_ce; // sysclkf_ce gated by enable
    logic r_ce; // sysclkr_ce gated by enable

    reset_enable reset_enable0 (
        .wclk        (wclk),
        .resetn      (resetn),
        .start       (start),
        .loading     (loading),
        .sdram_busy  (sdram_busy),
        .loader_fail (loader_fail),
        .frame_pause (frame_pause),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .core_resetn (core_resetn),
        .enable      (enable),
        .f_ce        (f_ce),
        .r_ce        (r_ce)
    );

    cpu_port_router cpu_port_router0 (
        .wclk (wclk), .resetn (resetn),
        .loading (loading), .loader_do (loader_do), .loader_do_valid (loader_do_valid),
        .f_ce (f_ce), .r_ce (r_ce),
        .rom_addr (rom_addr), .rom_ce_n (rom_ce_n), .rom_word (rom_word), .rom_q (rom_q),
        .wram_addr (wram_addr), .wram_ce_n (wram_ce_n), .wram_rd_n (wram_rd_n),
        .wram_we_n (wram_we_n), .wram_d (wram_d), .wram_q (wram_q),
        .cpu_addr (cpu_addr), .cpu_din (cpu_din), .cpu_ds (cpu_ds), .cpu_port (cpu_port),
        .cpu_rd (cpu_rd), .cpu_wr (cpu_wr),
        .cpu_port0 (cpu_port0), .cpu_port1 (cpu_port1)
    );

    aux_port_stage aux_port_stage0 (
        .wclk (wclk), .resetn (resetn),
        .f_ce (f_ce), .r_ce (r_ce), .map_type (map_type),
        .bsram_addr (bsram_addr), .bsram_ce_n (bsram_ce_n), .bsram_rd_n (bsram_rd_n),
        .bsram_we_n (bsram_we_n), .bsram_d (bsram_d),
        .aram_addr (aram_addr), .aram_ce_n (aram_ce_n), .aram_oe_n (aram_oe_n),
        .aram_we_n (aram_we_n), .aram_d (aram_d), .aram_q (aram_q),
        .bsram_req_addr (bsram_req_addr), .bsram_req_din (bsram_req_din),
        .bsram_req_rd (bsram_req_rd), .bsram_req_wr (bsram_req_wr),
        .aram_rd (aram_rd), .aram_wr (aram_wr),
        .aram_din (aram_din), .aram_dout (aram_dout)
    );

endmodule

// File: dv/snes_mem_asserts.sv
// concurrent checks on the SDRAM request strobes
// read/write exclusion, quiet strobes in reset, WRAM prefix on port 1 reads

`timescale 1ns/100ps

module snes_mem_asserts (
    input logic                                  wclk,
    input logic                                  resetn,
    input logic                                  cpu_rd,
    input logic                                  cpu_wr,
    input logic                                  cpu_port,
    input logic [sdram_port_pkg::cpu_addr_w-1:0] cpu_addr,
    input logic                                  bsram_req_rd,
    input logic                                  bsram_req_wr,
    input logic                                  enable,
    input logic                                  core_resetn
);
    import sdram_port_pkg::*;

    // one cpu port access per cycle
    rd_wr_exclusive: assert property (@(posedge wclk) disable iff (!resetn)
        !(cpu_rd && cpu_wr))
        else $error("cpu_rd and cpu_wr high in the same cycle");

    // registered strobes clear one edge into reset
    quiet_in_reset: assert property (@(posedge wclk)
        !resetn |=> !cpu_rd && !cpu_wr && !bsram_req_rd && !bsram_req_wr && !enable
                    && !core_resetn)
        else $error("strobe or enable high while resetn low");

    wram_read_prefix: assert property (@(posedge wclk) disable iff (!resetn)
        (cpu_rd && cpu_port == port_wram) |-> cpu_addr[cpu_addr_w-1 -: 7] == wram_prefix)
        else $error("port 1 read outside the WRAM banks");

endmodule

// File: dv/snes_mem_tb.sv
// testbench for the SNES memory glue top level
// clock, reset, SDRAM model on the cpu port, xorshift stimulus
// directed tests for reset, loader, ROM, WRAM, enable gating, BSRAM and ARAM

`timescale 1ns/100ps

module snes_mem_tb;
    import sdram_port_pkg::*;
    import snes_bus_pkg::*;

    localparam int load_n    = 16; // bytes written by the loader test
    localparam int rom_reads = 6;
    // rough cycle cost of each test
    localparam int len_reset  = 40 + reset_hold + 3 + 8;
    localparam int len_loader = load_n + 6;
    localparam int len_rom    = rom_reads * 8;
    localparam int len_wram   = 30;
    localparam int len_enable = 40;
    localparam int len_aux    = 30;
    localparam int timeout_cycles =
        2 * (3 + len_reset + len_loader + len_rom + len_wram + len_enable + len_aux);

    // control and core side, idle values
    logic wclk = 1'b0;
    logic resetn = 1'b0;
    logic start = 1'b0;
    logic sdram_busy = 1'b0;
    logic frame_pause = 1'b0;
    logic sysclkf_ce = 1'b0;
    logic sysclkr_ce = 1'b0;
    logic [map_type_w-1:0] map_type = '0;
    logic loading = 1'b0, loader_do_valid = 1'b0, loader_fail = 1'b0;
    logic [byte_w-1:0] loader_do = '0;
    logic [rom_addr_w-1:0] rom_addr = '0;
    logic rom_ce_n = 1'b1, rom_word = 1'b0;
    logic [wram_addr_w-1:0] wram_addr = '0;
    logic wram_ce_n = 1'b1, wram_rd_n = 1'b1, wram_we_n = 1'b1;
    logic [bsram_addr_w-1:0] bsram_addr = '0;
    logic bsram_ce_n = 1'b1, bsram_rd_n = 1'b1, bsram_we_n = 1'b1;
    logic [aram_addr_w-1:0] aram_addr = '0;
    logic aram_ce_n = 1'b1, aram_oe_n = 1'b1, aram_we_n = 1'b1;
    logic [byte_w-1:0] wram_d = '0, bsram_d = '0, aram_d = '0;
    logic [data_w-1:0] cpu_port0 = '0, cpu_port1 = '0, aram_dout = '0;

    // DUT outputs
    logic core_resetn, enable, cpu_port, cpu_rd, cpu_wr;
    logic bsram_req_rd, bsram_req_wr, aram_rd, aram_wr;
    logic [data_w-1:0] rom_q, cpu_din, aram_din;
    logic [byte_w-1:0] wram_q, aram_q, bsram_req_din;
    logic [cpu_addr_w-1:0] cpu_addr;
    logic [ds_w-1:0] cpu_ds;
    logic [bsram_addr_w-1:0] bsram_req_addr;

    logic [15:0] sdram_mem [0:(1<<17)-1]; // rom words low half, wram high half
    logic [7:0]  rom_img [0:load_n-1];    // bytes the loader sent
    logic [31:0] rand_state = 32'h66db2ef3;
    int errors = 0;
    int err_base = 0;
    int tests = 0;
    int tests_failed = 0;
    int cycle_cnt = 0;

    snes_mem_top dut0 (.*);

    bind snes_mem_top snes_mem_asserts asserts0 (.*);

    always #20 wclk = ~wclk; // 40 ns period

    // run limit
    always @(posedge wclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // sdram model, bit 23 splits rom from wram
    always @(posedge wclk) begin
        if (cpu_wr) begin
            if (cpu_ds[0]) sdram_mem[{cpu_addr[23], cpu_addr[16:1]}][7:0] <= cpu_din[7:0];
            if (cpu_ds[1]) sdram_mem[{cpu_addr[23], cpu_addr[16:1]}][15:8] <= cpu_din[15:8];
        end
        if (cpu_rd && cpu_port == port_wram) begin
            cpu_port1 <= sdram_mem[{cpu_addr[23], cpu_addr[16:1]}];
        end else if (cpu_rd) begin
            cpu_port0 <= sdram_mem[{cpu_addr[23], cpu_addr[16:1]}];
        end
    end

    function automatic logic [31:0] xorshift32();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    // even byte low lane; odd byte reads come back in the low byte
    function automatic logic [15:0] expected_rom(input logic [23:0] a, input logic word);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = rom_img[{a[23:1], 1'b0}];
        hi = rom_img[{a[23:1], 1'b1}];
        if (word || !a[0]) return {hi, lo};
        return {lo, hi};
    endfunction

    function automatic logic strobe_high(input int which);
        case (which)
            0: return cpu_rd;
            1: return cpu_wr;
            2: return bsram_req_rd;
            default: return bsram_req_wr;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors > err_base) tests_failed++;
        $display("%s: %s, %0d errors", name, (errors > err_base) ? "FAIL" : "ok", errors - err_base);
        err_base = errors;
    endtask

    // one cycle pulse on the fall or rise phase
    task automatic pulse_phase(input logic fall);
        @(posedge wclk);
        if (fall) sysclkf_ce <= 1'b1;
        else sysclkr_ce <= 1'b1;
        @(posedge wclk);
        sysclkf_ce <= 1'b0;
        sysclkr_ce <= 1'b0;
    endtask

    task automatic wait_strobe(input int which, input string name);
        int n;
        n = 0;
        do begin
            @(negedge wclk);
            n++;
        end while (!strobe_high(which) && n < 8);
        if (!strobe_high(which)) begin
            errors++;
            $display("error at %0t: no %s pulse within 8 cycles", $time, name);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge wclk);
            if (cpu_rd || cpu_wr || bsram_req_rd || bsram_req_wr)
                report_mismatch("request strobe where none is allowed");
        end
    endtask

    task automatic reset_sequencing();
        int n;
        for (n = 0; n < 40; n++) begin
            @(negedge wclk);
            if (core_resetn !== 1'b0) report_mismatch("core_resetn high while start low");
        end
        @(posedge wclk);
        start <= 1'b1;
        n = 0;
        while (core_resetn !== 1'b1 && n <= reset_hold + 3) begin
            @(negedge wclk);
            n++;
        end
        if (core_resetn !== 1'b1) report_mismatch("core_resetn not released after start");
        @(posedge wclk);
        loading <= 1'b1;
        @(negedge wclk);
        if (core_resetn !== 1'b0) report_mismatch("core_resetn high while loading");
        @(posedge wclk);
        loading <= 1'b0;
        @(negedge wclk);
        if (core_resetn !== 1'b1) report_mismatch("core_resetn low after loading ends");
        close_test("reset sequencing");
    endtask

    task automatic loader_writes();
        int i;
        logic [31:0] r;
        logic [1:0] ds;
        @(posedge wclk);
        loading <= 1'b1;
        rom_ce_n <= 1'b0; // rom select held through the stream
        sysclkf_ce <= 1'b1;
        for (i = 0; i <= load_n; i++) begin
            @(posedge wclk);
            if (i < load_n) begin
                r = xorshift32();
                rom_img[i] = r[7:0];
                loader_do <= r[7:0];
                loader_do_valid <= 1'b1;
            end else begin
                loader_do_valid <= 1'b0;
                rom_ce_n <= 1'b1;
                sysclkf_ce <= 1'b0;
            end
            @(negedge wclk);
            if (cpu_rd !== 1'b0) report_mismatch("read issued during loader write");
            if (i > 0) begin
                ds = ((i - 1) % 2 == 1) ? 2'b10 : 2'b01; // odd byte on high lane
                if (cpu_wr !== 1'b1 || cpu_addr !== 24'(i - 1) || cpu_ds !== ds ||
                    cpu_din !== {rom_img[i-1], rom_img[i-1]})
                    report_mismatch($sformatf("loader byte %0d: wr %b addr %h ds %b din %h",
                        i - 1, cpu_wr, cpu_addr, cpu_ds, cpu_din));
            end
        end
        @(posedge wclk);
        loading <= 1'b0;
        close_test("loader writes");
    endtask

    task automatic rom_read_back();
        int k;
        logic [31:0] r;
        logic [23:0] a;
        for (k = 0; k < rom_reads; k++) begin
            r = xorshift32();
            a = 24'(r[7:0] % load_n);
            @(posedge wclk);
            rom_addr <= a;
            rom_word <= r[8];
            rom_ce_n <= 1'b0;
            pulse_phase(1'b1);
            wait_strobe(0, "cpu_rd");
            if (cpu_port !== port_rom || cpu_ds !== 2'b11 || cpu_addr !== a)
                report_mismatch($sformatf("rom read %h: port %b ds %b", cpu_addr, cpu_port, cpu_ds));
            @(negedge wclk);
            if (cpu_rd !== 1'b0) report_mismatch("rom select gave more than one read");
            if (rom_q !== expected_rom(a, r[8]))
                report_mismatch($sformatf("rom_q %h at %h word %b", rom_q, a, r[8]));
            @(posedge wclk);
            rom_ce_n <= 1'b1;
        end
        close_test("rom reads");
    endtask

    task automatic wram_access();
        logic [31:0] r;
        r = xorshift32();
        @(posedge wclk);
        wram_addr <= r[16:0];
        wram_d <= r[31:24];
        wram_ce_n <= 1'b0;
        wram_we_n <= 1'b0;
        pulse_phase(1'b1); // fall phase alone, no write
        expect_quiet(3);
        pulse_phase(1'b0);
        wait_strobe(1, "cpu_wr");
        if (cpu_port !== port_wram || cpu_addr !== {wram_prefix, r[16:0]} ||
            cpu_din !== {r[31:24], r[31:24]})
            report_mismatch($sformatf("wram write addr %h din %h", cpu_addr, cpu_din));
        @(posedge wclk);
        wram_we_n <= 1'b1;
        wram_rd_n <= 1'b0;
        pulse_phase(1'b0); // rise phase alone, no read
        expect_quiet(3);
        pulse_phase(1'b1);
        wait_strobe(0, "cpu_rd");
        if (cpu_port !== port_wram || cpu_addr !== {wram_prefix, r[16:0]})
            report_mismatch($sformatf("wram read addr %h port %b", cpu_addr, cpu_port));
        @(negedge wclk);
        if (wram_q !== r[31:24]) report_mismatch($sformatf("wram_q %h", wram_q));
        @(posedge wclk);
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
        close_test("wram access");
    endtask

    task automatic enable_gating();
        int k;
        @(posedge wclk);
        rom_ce_n <= 1'b0;  // read on fall phase
        wram_ce_n <= 1'b0; // write on rise phase
        wram_we_n <= 1'b0;
        bsram_ce_n <= 1'b0;
        bsram_rd_n <= 1'b0;
        for (k = 0; k < 2; k++) begin
            @(posedge wclk);
            sdram_busy <= (k == 0);
            frame_pause <= (k == 1);
            repeat (2) @(posedge wclk);
            @(negedge wclk);
            if (enable !== 1'b0) report_mismatch("enable high while held off");
            pulse_phase(1'b1);
            expect_quiet(3); // rom and bsram reads stay off
            pulse_phase(1'b0);
            expect_quiet(3); // wram write stays off
        end
        @(posedge wclk);
        sdram_busy <= 1'b0;
        frame_pause <= 1'b0;
        pulse_phase(1'b1);
        wait_strobe(0, "cpu_rd");
        if (bsram_req_rd !== 1'b1 || enable !== 1'b1)
            report_mismatch("bsram read or enable missing after resume");
        pulse_phase(1'b0);
        wait_strobe(1, "cpu_wr");
        @(posedge wclk);
        rom_ce_n <= 1'b1;
        wram_ce_n <= 1'b1;
        wram_we_n <= 1'b1;
        bsram_ce_n <= 1'b1;
        bsram_rd_n <= 1'b1;
        close_test("enable gating");
    endtask

    task automatic bsram_and_aram();
        int k;
        logic [31:0] r;
        logic [31:0] d;
        r = xorshift32();
        @(posedge wclk);
        map_type <= 8'h21;
        bsram_addr <= r[19:0];
        bsram_ce_n <= 1'b0; // rd_n stays high
        pulse_phase(1'b1);
        expect_quiet(3);
        @(posedge wclk);
        map_type <= 8'hC5;  // SA map reads without rd_n
        pulse_phase(1'b1);
        wait_strobe(2, "bsram_req_rd");
        @(posedge wclk);
        map_type <= 8'h21;
        bsram_d <= r[31:24];
        bsram_we_n <= 1'b0;
        pulse_phase(1'b0);
        wait_strobe(3, "bsram_req_wr");
        if (bsram_req_addr !== r[19:0] || bsram_req_din !== r[31:24])
            report_mismatch($sformatf("bsram write %h data %h", bsram_req_addr, bsram_req_din));
        @(posedge wclk);
        bsram_ce_n <= 1'b1;
        bsram_we_n <= 1'b1;
        d = xorshift32();
        aram_dout <= d[15:0];
        for (k = 0; k < 2; k++) begin
            @(posedge wclk);
            aram_addr <= {d[31:17], k[0]};
            aram_ce_n <= 1'b0;
            aram_oe_n <= 1'b0;
            @(negedge wclk);
            if (aram_rd !== 1'b1 || aram_wr !== 1'b0) report_mismatch("aram read strobes");
            @(posedge wclk);
            aram_addr <= {d[31:17], ~k[0]}; // latch must keep the read lsb
            aram_ce_n <= 1'b1;
            aram_oe_n <= 1'b1;
            @(negedge wclk);
            if (aram_q !== (k[0] ? d[15:8] : d[7:0]))
                report_mismatch($sformatf("aram_q %h lsb %0d", aram_q, k));
        end
        @(posedge wclk);
        aram_ce_n <= 1'b0;
        aram_we_n <= 1'b0;
        aram_d <= r[7:0];
        @(negedge wclk);
        if (aram_wr !== 1'b1 || aram_din !== {r[7:0], r[7:0]})
            report_mismatch($sformatf("aram write din %h", aram_din));
        @(posedge wclk);
        aram_ce_n <= 1'b1;
        aram_we_n <= 1'b1;
        close_test("bsram and aram");
    endtask

    initial begin
        repeat (3) @(posedge wclk);
        resetn <= 1'b1;
        reset_sequencing();
        loader_writes();
        rom_read_back();
        wram_access();
        enable_gating();
        bsram_and_aram();
        $display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/sdram_port_pkg.sv
hw/snes_bus_pkg.sv
hw/reset_enable.sv
hw/cpu_port_router.sv
hw/aux_port_stage.sv
hw/snes_mem_top.sv
dv/snes_mem_asserts.sv
dv/snes_mem_tb.sv

// File: Bender.yml
package:
  name: snes_mem

sources:
  - hw/sdram_port_pkg.sv
  - hw/snes_bus_pkg.sv
  - hw/reset_enable.sv
  - hw/cpu_port_router.sv
  - hw/aux_port_stage.sv
  - hw/snes_mem_top.sv
  - target: test
    files:
      - dv/snes_mem_asserts.sv
      - dv/snes_mem_tb.sv
